/* design/mipsPkg.sv */
/* mips package
   widths, opcode and function codes, control bundle and the four stage payloads */
package mipsPkg;

	localparam int xLen     = 32; // data and address width, one word
	localparam int regAddrW = 5;  // 32 registers
	localparam logic [xLen-1:0] resetPc = '0;

	// main opcodes, instn[31:26]
	localparam logic [5:0] opRType = 6'b000000;
	localparam logic [5:0] opLw    = 6'b100011;
	localparam logic [5:0] opSw    = 6'b101011;
	localparam logic [5:0] opBeq   = 6'b000100;
	localparam logic [5:0] opAddi  = 6'b001000;
	localparam logic [5:0] opJ     = 6'b000010;

	// r-type function field, instn[5:0]
	localparam logic [5:0] functAdd = 6'b100000;
	localparam logic [5:0] functSub = 6'b100010;
	localparam logic [5:0] functAnd = 6'b100100;
	localparam logic [5:0] functOr  = 6'b100101;
	localparam logic [5:0] functSlt = 6'b101010;

	// classic alucontrol encoding
	typedef enum logic [2:0] {
		aluAnd = 3'b000,
		aluOr  = 3'b001,
		aluAdd = 3'b010,
		aluSub = 3'b110,
		aluSlt = 3'b111
	} aluOpT;

	typedef struct packed {
		logic  regWrite;
		logic  memToReg; // result from dmem instead of alu
		logic  memWrite;
		logic  regDst;   // rd when set, else rt
		logic  aluSrc;   // immediate as alu operand b
		aluOpT aluOp;
	} ctrlT;

	typedef enum logic [1:0] {
		fwdReg = 2'b00, // value read in decode
		fwdWb  = 2'b01,
		fwdMem = 2'b10
	} fwdSelT;

	typedef struct packed {
		logic [xLen-1:0] instn;
		logic [xLen-1:0] pcPlus4;
	} ifIdT;

	typedef struct packed {
		ctrlT                ctrl;
		logic [xLen-1:0]     a;
		logic [xLen-1:0]     b;
		logic [xLen-1:0]     signImm;
		logic [regAddrW-1:0] rs;
		logic [regAddrW-1:0] rt;
		logic [regAddrW-1:0] rd;
	} idExT;

	typedef struct packed {
		logic                regWrite;
		logic                memToReg;
		logic                memWrite;
		logic [xLen-1:0]     aluOut;
		logic [xLen-1:0]     writeData; // store data, already forwarded
		logic [regAddrW-1:0] writeReg;
	} exMemT;

	typedef struct packed {
		logic                regWrite;
		logic                memToReg;
		logic [xLen-1:0]     aluOut;
		logic [xLen-1:0]     readData;
		logic [regAddrW-1:0] writeReg;
	} memWbT;

endpackage : mipsPkg

/* design/pipeRegister.sv */
/* pipeline stage register
   holds one stage payload, with stall (hold) and flush (bubble) */
`timescale 1ns/1ps
module pipeRegister #(
	parameter type payloadT = logic [31:0]
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    stall, // hold current payload
	input  logic    flush, // insert bubble, beats stall
	input  payloadT d,
	output payloadT q
);

	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			q <= '0; // all-zero payload is a no-op
		end else if (!stall) begin
			q <= d;
		end
	end

	// a stalled stage must present the same instruction next cycle
	holdOnStall : assert property (@(posedge clk) disable iff (!rstN)
		(rstN && stall && !flush) |=> $stable(q));

endmodule : pipeRegister

/* design/fetchStage.sv */
/* fetch stage
   pc register and next-pc select, jump over taken branch over pc+4 */
`timescale 1ns/1ps
module fetchStage (
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      stall,
	input  logic                      pcSrc,      // taken beq in decode
	input  logic                      jump,       // j in decode
	input  logic [mipsPkg::xLen-1:0] pcBranch,
	input  logic [mipsPkg::xLen-1:0] jumpTarget,
	output logic [mipsPkg::xLen-1:0] pc,
	output logic [mipsPkg::xLen-1:0] pcPlus4
);
	import mipsPkg::*;

	logic [xLen-1:0] pcNext;

	assign pcPlus4 = pc + xLen'(4);

	always_comb begin
		if (jump)
			pcNext = jumpTarget;
		else if (pcSrc)
			pcNext = pcBranch;
		else
			pcNext = pcPlus4; // sequential
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= resetPc;
		end else if (!stall) begin
			pc <= pcNext;
		end
	end

	// targets from decode keep the low bits clear
	pcAligned : assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule : fetchStage

/* design/controller.sv */
/* main and alu decoder
   opcode and funct to the control bundle, plus branch and jump for decode */
`timescale 1ns/1ps
module controller (
	input  logic [5:0]     op,
	input  logic [5:0]     funct,
	output mipsPkg::ctrlT ctrl,
	output logic           branch,
	output logic           jump
);
	import mipsPkg::*;

	always_comb begin
		ctrl   = '0; // default bundle does nothing
		branch = 1'b0;
		jump   = 1'b0;
		unique case (op)
			opRType: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = 1'b1;
				unique case (funct)
					functAdd: ctrl.aluOp = aluAdd;
					functSub: ctrl.aluOp = aluSub;
					functAnd: ctrl.aluOp = aluAnd;
					functOr:  ctrl.aluOp = aluOr;
					functSlt: ctrl.aluOp = aluSlt;
					default:  ctrl = '0; // unknown funct, also the all-zero nop
				endcase
			end
			opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAdd; // base + offset
			end
			opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			opBeq:   branch = 1'b1; // compared in decode, no execute work
			opJ:     jump   = 1'b1;
			default: ctrl   = '0;
		endcase
	end

endmodule : controller

/* design/decodeStage.sv */
/* decode stage
   register file, immediate, early beq compare with mem forwarding, branch and jump targets */
`timescale 1ns/1ps
module decodeStage (
	input  logic                          clk,
	input  mipsPkg::ifIdT                ifId,
	input  mipsPkg::ctrlT                ctrl,
	input  logic                          branch,
	input  logic                          forwardAD,  // compare operand a from mem stage
	input  logic                          forwardBD,
	input  logic [mipsPkg::xLen-1:0]     aluOutM,
	input  logic                          wbRegWrite,
	input  logic [mipsPkg::regAddrW-1:0] wbWriteReg,
	input  logic [mipsPkg::xLen-1:0]     resultW,
	output mipsPkg::idExT                idEx,
	output logic                          pcSrc,
	output logic [mipsPkg::xLen-1:0]     pcBranch,
	output logic [mipsPkg::xLen-1:0]     jumpTarget
);
	import mipsPkg::*;

	logic [xLen-1:0]     rf [32];
	logic [regAddrW-1:0] rs;
	logic [regAddrW-1:0] rt;
	logic [regAddrW-1:0] rd;
	logic [xLen-1:0]     rdA;
	logic [xLen-1:0]     rdB;
	logic [xLen-1:0]     cmpA;
	logic [xLen-1:0]     cmpB;
	logic [xLen-1:0]     signImm;

	assign rs = ifId.instn[25:21];
	assign rt = ifId.instn[20:16];
	assign rd = ifId.instn[15:11];

	// write in the first half, read in the second: wb to decode needs no bypass
	always_ff @(negedge clk) begin
		if (wbRegWrite)
			rf[wbWriteReg] <= resultW;
	end

	assign rdA = (rs == '0) ? '0 : rf[rs]; // $zero hardwired
	assign rdB = (rt == '0) ? '0 : rf[rt];

	assign signImm = {{(xLen-16){ifId.instn[15]}}, ifId.instn[15:0]};

	// beq resolves here, so only alu results in mem can be bypassed
	assign cmpA  = forwardAD ? aluOutM : rdA;
	assign cmpB  = forwardBD ? aluOutM : rdB;
	assign pcSrc = branch && (cmpA == cmpB);

	assign pcBranch   = ifId.pcPlus4 + (signImm << 2);
	assign jumpTarget = {ifId.pcPlus4[xLen-1:28], ifId.instn[25:0], 2'b00}; // pseudo-direct

	assign idEx = '{
		ctrl:    ctrl,
		a:       rdA,
		b:       rdB,
		signImm: signImm,
		rs:      rs,
		rt:      rt,
		rd:      rd
	};

	// execute drops regWrite for a $zero destination
	noZeroWrite : assert property (@(negedge clk) wbRegWrite |-> wbWriteReg != '0);

endmodule : decodeStage

/* design/executeStage.sv */
/* execute stage
   operand forwarding, alu source select, alu and destination register */
`timescale 1ns/1ps
module executeStage (
	input  mipsPkg::idExT             idEx,
	input  mipsPkg::fwdSelT           forwardAE,
	input  mipsPkg::fwdSelT           forwardBE,
	input  logic [mipsPkg::xLen-1:0] aluOutM,
	input  logic [mipsPkg::xLen-1:0] resultW,
	output mipsPkg::exMemT            exMem
);
	import mipsPkg::*;

	logic [xLen-1:0]     srcA;
	logic [xLen-1:0]     fwdB; // also the store data
	logic [xLen-1:0]     srcB;
	logic [xLen-1:0]     aluOut;
	logic [regAddrW-1:0] writeReg;

	always_comb begin
		unique case (forwardAE)
			fwdMem:  srcA = aluOutM;
			fwdWb:   srcA = resultW;
			default: srcA = idEx.a;
		endcase
		unique case (forwardBE)
			fwdMem:  fwdB = aluOutM;
			fwdWb:   fwdB = resultW;
			default: fwdB = idEx.b;
		endcase
	end

	assign srcB = idEx.ctrl.aluSrc ? idEx.signImm : fwdB;

	always_comb begin
		unique case (idEx.ctrl.aluOp)
			aluAdd:  aluOut = srcA + srcB;
			aluSub:  aluOut = srcA - srcB;
			aluAnd:  aluOut = srcA & srcB;
			aluOr:   aluOut = srcA | srcB;
			aluSlt:  aluOut = ($signed(srcA) < $signed(srcB)) ? xLen'(1) : '0;
			default: aluOut = '0;
		endcase
	end

	assign writeReg = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

	assign exMem = '{
		regWrite:  idEx.ctrl.regWrite && (writeReg != '0), // writes to $zero vanish here
		memToReg:  idEx.ctrl.memToReg,
		memWrite:  idEx.ctrl.memWrite,
		aluOut:    aluOut,
		writeData: fwdB,
		writeReg:  writeReg
	};

endmodule : executeStage

/* design/hazardUnit.sv */
/* hazard unit
   bypass selects for execute and the decode compare, load-use and branch stalls */
`timescale 1ns/1ps
module hazardUnit (
	input  logic [mipsPkg::regAddrW-1:0] rsD,
	input  logic [mipsPkg::regAddrW-1:0] rtD,
	input  logic                          branch,
	input  logic                          jump,
	input  mipsPkg::idExT                idExQ,
	input  mipsPkg::exMemT               exMemQ,
	input  mipsPkg::memWbT               memWbQ,
	output logic                          stallF,
	output logic                          stallD,
	output logic                          flushE,
	output logic                          forwardAD,
	output logic                          forwardBD,
	output mipsPkg::fwdSelT              forwardAE,
	output mipsPkg::fwdSelT              forwardBE
);
	import mipsPkg::*;

	logic [regAddrW-1:0] writeRegE;
	logic                lwStall;
	logic                branchStall;

	assign writeRegE = idExQ.ctrl.regDst ? idExQ.rd : idExQ.rt;

	// youngest producer wins, regWrite already false for $zero
	always_comb begin
		if (exMemQ.regWrite && idExQ.rs == exMemQ.writeReg)      forwardAE = fwdMem;
		else if (memWbQ.regWrite && idExQ.rs == memWbQ.writeReg) forwardAE = fwdWb;
		else                                                     forwardAE = fwdReg;
		if (exMemQ.regWrite && idExQ.rt == exMemQ.writeReg)      forwardBE = fwdMem;
		else if (memWbQ.regWrite && idExQ.rt == memWbQ.writeReg) forwardBE = fwdWb;
		else                                                     forwardBE = fwdReg;
	end

	assign forwardAD = exMemQ.regWrite && (rsD == exMemQ.writeReg); // alu result only
	assign forwardBD = exMemQ.regWrite && (rtD == exMemQ.writeReg);

	// j reads no registers, its target bits must not match a load
	assign lwStall = idExQ.ctrl.memToReg && !jump && (idExQ.rt == rsD || idExQ.rt == rtD);

	// beq waits for an alu op in execute, or a load in execute then in memory
	assign branchStall = branch && (
		(idExQ.ctrl.regWrite && writeRegE != '0 && (writeRegE == rsD || writeRegE == rtD)) ||
		(exMemQ.memToReg && exMemQ.regWrite &&
		 (exMemQ.writeReg == rsD || exMemQ.writeReg == rtD)));

	assign stallD = lwStall || branchStall;
	assign stallF = stallD;
	assign flushE = stallD; // bubble behind the held instruction

	always_comb begin
		if (stallD)
			assert final (!jump); // the jump flush of decode never meets a stall
		if (forwardAE != fwdReg)
			assert final (idExQ.rs != '0);
		if (forwardBE != fwdReg)
			assert final (idExQ.rt != '0);
		if (forwardAD || forwardBD)
			assert final ((!forwardAD || rsD != '0) && (!forwardBD || rtD != '0));
	end

endmodule : hazardUnit

/* design/mips.sv */
/* mips core top
   five-stage pipeline, single-cycle instruction and data memory ports */
`timescale 1ns/1ps
module mips (
	input  logic                      clk,
	input  logic                      rstN,
	output logic [mipsPkg::xLen-1:0] pcImem,
	input  logic [mipsPkg::xLen-1:0] imemInstn,
	output logic                      dmemWe,
	output logic [mipsPkg::xLen-1:0] dmemAddr,
	output logic [mipsPkg::xLen-1:0] dmemWd,
	input  logic [mipsPkg::xLen-1:0] dmemRd
);
	import mipsPkg::*;

	logic [xLen-1:0] pcPlus4F;
	ifIdT            ifIdD;
	ifIdT            ifIdQ;
	idExT            idExD;
	idExT            idExQ;
	exMemT           exMemD;
	exMemT           exMemQ;
	memWbT           memWbD;
	memWbT           memWbQ;
	ctrlT            ctrlD;
	logic            branchD;
	logic            jumpD;
	logic            pcSrcD;
	logic [xLen-1:0] pcBranchD;
	logic [xLen-1:0] jumpTargetD;
	logic [xLen-1:0] resultW;
	logic            stallF;
	logic            stallD;
	logic            flushD;
	logic            flushE;
	logic            forwardAD;
	logic            forwardBD;
	fwdSelT          forwardAE;
	fwdSelT          forwardBE;

	// drop the wrong-path fetch, unless decode is held for a stale compare
	assign flushD = (pcSrcD || jumpD) && !stallD;

	assign ifIdD = '{instn: imemInstn, pcPlus4: pcPlus4F};

	// memory stage
	assign dmemWe   = exMemQ.memWrite;
	assign dmemAddr = exMemQ.aluOut;
	assign dmemWd   = exMemQ.writeData;
	assign memWbD = '{
		regWrite: exMemQ.regWrite,
		memToReg: exMemQ.memToReg,
		aluOut:   exMemQ.aluOut,
		readData: dmemRd,
		writeReg: exMemQ.writeReg
	};

	assign resultW = memWbQ.memToReg ? memWbQ.readData : memWbQ.aluOut; // writeback mux

	fetchStage fetch (
		.clk(clk), .rstN(rstN), .stall(stallF),
		.pcSrc(pcSrcD), .jump(jumpD), .pcBranch(pcBranchD), .jumpTarget(jumpTargetD),
		.pc(pcImem), .pcPlus4(pcPlus4F)
	);

	pipeRegister #(.payloadT(ifIdT)) ifIdReg (
		.clk(clk), .rstN(rstN), .stall(stallD), .flush(flushD), .d(ifIdD), .q(ifIdQ)
	);

	controller ctrlDec (
		.op(ifIdQ.instn[31:26]), .funct(ifIdQ.instn[5:0]),
		.ctrl(ctrlD), .branch(branchD), .jump(jumpD)
	);

	decodeStage decode (
		.clk(clk), .ifId(ifIdQ), .ctrl(ctrlD), .branch(branchD),
		.forwardAD(forwardAD), .forwardBD(forwardBD), .aluOutM(exMemQ.aluOut),
		.wbRegWrite(memWbQ.regWrite), .wbWriteReg(memWbQ.writeReg), .resultW(resultW),
		.idEx(idExD), .pcSrc(pcSrcD), .pcBranch(pcBranchD), .jumpTarget(jumpTargetD)
	);

	pipeRegister #(.payloadT(idExT)) idExReg (
		.clk(clk), .rstN(rstN), .stall(1'b0), .flush(flushE), .d(idExD), .q(idExQ)
	);

	executeStage execute (
		.idEx(idExQ), .forwardAE(forwardAE), .forwardBE(forwardBE),
		.aluOutM(exMemQ.aluOut), .resultW(resultW), .exMem(exMemD)
	);

	pipeRegister #(.payloadT(exMemT)) exMemReg (
		.clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(exMemD), .q(exMemQ)
	);

	pipeRegister #(.payloadT(memWbT)) memWbReg (
		.clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ)
	);

	hazardUnit hazard (
		.rsD(ifIdQ.instn[25:21]), .rtD(ifIdQ.instn[20:16]), .branch(branchD), .jump(jumpD),
		.idExQ(idExQ), .exMemQ(exMemQ), .memWbQ(memWbQ),
		.stallF(stallF), .stallD(stallD), .flushE(flushE),
		.forwardAD(forwardAD), .forwardBD(forwardBD),
		.forwardAE(forwardAE), .forwardBE(forwardBE)
	);

endmodule : mips

/* test/mipsTb.sv */
/* mips core testbench
   memory models, small assembler with a shadow register model, store checks by assertions */
`timescale 1ns/1ps
module mipsTb;
	import mipsPkg::*;

	localparam int resetLen = 4;
	localparam logic [31:0] markerAddr = 32'h0000_07f0; // only wrong-path stores aim here

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [7:0]  testId;
	} expStoreT;

	logic        clk;
	logic        rstN;
	logic [31:0] pcImem;
	logic [31:0] imemInstn;
	logic        dmemWe;
	logic [31:0] dmemAddr;
	logic [31:0] dmemWd;
	logic [31:0] dmemRd;

	logic [31:0] imem [256];
	logic [31:0] dmem [512];
	logic [31:0] regs [32]; // what the program leaves in each register
	expStoreT    expQ [$];
	expStoreT    head;       // next store due
	int          pending;
	int          progLen;
	int          resetCycles;
	bit          progReady;
	integer      seed;
	string       testName [6] = '{"reset", "aluChain", "loadUse", "branchTaken",
		"branchNotTaken", "regZero"};

	mips uut (.*);

	assign imemInstn = imem[pcImem[9:2]]; // same-cycle instruction read
	assign dmemRd    = dmem[dmemAddr[10:2]];

	always @(posedge clk) begin
		if (dmemWe)
			dmem[dmemAddr[10:2]] <= dmemWd;
		if (!rstN)
			resetCycles <= resetCycles + 1;
		if (rstN && dmemWe && expQ.size() != 0) begin
			void'(expQ.pop_front());
			pending <= pending - 1;
			if (expQ.size() != 0)
				head <= expQ[0];
		end
	end

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic failRun(string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1);
	endtask

	function automatic logic [31:0] fillWord(int idx);
		return (32'(idx) * 32'h9e37_79b1) ^ 32'h5ac3_0f69; // every index bit matters
	endfunction

	function automatic logic [31:0] signExt(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic logic [15:0] nextImm();
		return 16'($random(seed));
	endfunction

	// alu rules of the instruction set with a signed slt
	function automatic logic [31:0] aluResult(logic [5:0] funct, logic [31:0] a, logic [31:0] b);
		case (funct)
			functAdd: return a + b;
			functSub: return a - b;
			functAnd: return a & b;
			functOr:  return a | b;
			default:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] rType(logic [5:0] funct, int rd, int rs, int rt);
		return {opRType, 5'(rs), 5'(rt), 5'(rd), 5'b0, funct};
	endfunction

	function automatic logic [31:0] iType(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	task automatic emit(logic [31:0] instn);
		imem[progLen] = instn;
		progLen++;
	endtask

	task automatic expectStore(logic [31:0] addr, logic [31:0] data, int testId);
		expQ.push_back('{addr: addr, data: data, testId: 8'(testId)});
	endtask

	task automatic addImm(int rt, int rs, logic [15:0] imm);
		emit(iType(opAddi, rs, rt, imm));
		if (rt != 0)
			regs[rt] = regs[rs] + signExt(imm); // $zero keeps zero
	endtask

	task automatic aluInstr(logic [5:0] funct, int rd, int rs, int rt);
		emit(rType(funct, rd, rs, rt));
		if (rd != 0)
			regs[rd] = aluResult(funct, regs[rs], regs[rt]);
	endtask

	task automatic loadWord(int rt, int rs, logic [15:0] off);
		emit(iType(opLw, rs, rt, off));
		regs[rt] = fillWord((regs[rs] + signExt(off)) >> 2); // load area is never stored to
	endtask

	task automatic storeWord(int rt, int rs, logic [15:0] off, int testId);
		emit(iType(opSw, rs, rt, off));
		expectStore(regs[rs] + signExt(off), regs[rt], testId);
	endtask

	task automatic wrongPathStore(int rt);
		emit(iType(opSw, 0, rt, markerAddr[15:0])); // never expected
	endtask

	task automatic branchEq(int rs, int rt, logic [15:0] off);
		emit(iType(opBeq, rs, rt, off));
	endtask

	task automatic jumpTo(int target);
		emit({opJ, 26'(target)});
	endtask

	task automatic buildProgram();
		logic [15:0] base;
		for (int r = 0; r < 2; r++) begin
			base = 16'h0100 + 16'(r * 32);
			addImm(1, 0, nextImm());
			addImm(2, 0, nextImm());
			aluInstr(functAdd, 3, 1, 2); // r2 from mem, r1 from wb
			aluInstr(functSub, 4, 3, 1);
			aluInstr(functAnd, 5, 4, 3);
			aluInstr(functOr, 6, 5, 4);
			aluInstr(functSlt, 7, 6, 5);
			aluInstr(functSlt, 8, 1, 2);
			for (int k = 0; k < 6; k++)
				storeWord(3 + k, 0, base + 16'(4 * k), 1);
		end
		loadWord(9, 0, 16'h0400);
		aluInstr(functAdd, 10, 9, 1); // load-use stall
		storeWord(10, 0, 16'h0140, 2);
		loadWord(11, 0, 16'h0404);
		storeWord(11, 0, 16'h0144, 2); // store data straight from a load
		aluInstr(functAdd, 12, 1, 0);
		branchEq(12, 1, 16'd1); // taken right after the alu op
		wrongPathStore(2);
		storeWord(12, 0, 16'h0180, 3);
		loadWord(13, 0, 16'h0404);
		branchEq(13, 11, 16'd1); // two stall cycles behind the load, equal only to the loaded word
		wrongPathStore(2);
		storeWord(13, 0, 16'h0184, 3);
		addImm(15, 0, nextImm() | 16'h0001); // nonzero so the beq below falls through
		branchEq(15, 0, 16'd1);
		storeWord(15, 0, 16'h0188, 4);
		storeWord(1, 0, 16'h018c, 4);
		jumpTo(progLen + 2);
		wrongPathStore(1);
		storeWord(2, 0, 16'h0190, 4);
		addImm(0, 0, nextImm());
		storeWord(0, 0, 16'h01a0, 5);
		aluInstr(functAdd, 16, 0, 1);
		storeWord(16, 0, 16'h01a4, 5);
		jumpTo(progLen); // park here
	endtask

	resetQuiet : assert property (@(posedge clk)
		(resetCycles != 0 && (!rstN || $rose(rstN))) |-> (!dmemWe && pcImem == resetPc))
		else failRun("reset: store enable high or pc not at reset value during reset");

	storeMatch : assert property (@(posedge clk) disable iff (!rstN)
		(dmemWe && pending != 0) |-> (dmemAddr == head.addr && dmemWd == head.data))
		else failRun($sformatf("ERR %s: expected addr %h data %h, actual addr %h data %h",
			testName[$sampled(head.testId)], $sampled(head.addr), $sampled(head.data),
			$sampled(dmemAddr), $sampled(dmemWd)));

	storeExpected : assert property (@(posedge clk) disable iff (!rstN) dmemWe |-> pending != 0)
		else failRun("a store happened after all expected stores were done");

	markerUntouched : assert property (@(posedge clk) disable iff (!rstN)
		dmemWe |-> dmemAddr != markerAddr)
		else failRun("an instruction on the wrong path of a branch or jump stored to memory");

	initial begin
		wait (progReady);
		repeat (resetLen + progLen * 4) @(posedge clk);
		failRun("timeout: the program did not finish its stores in time");
	end

	initial begin
		rstN        = 1'b0;
		seed        = 32'h17ee_cacc;
		progLen     = 0;
		resetCycles = 0;
		for (int i = 0; i < 256; i++)
			imem[i] = '0; // all-zero word is a nop
		for (int i = 0; i < 512; i++)
			dmem[i] = fillWord(i);
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		buildProgram();
		head      = expQ[0];
		pending   = expQ.size();
		progReady = 1'b1;
		repeat (resetLen) @(posedge clk);
		#1 rstN = 1'b1;
		while (pending != 0)
			@(posedge clk);
		repeat (8) @(posedge clk); // drain and catch late stray stores
		$display("All tests passed!");
		$finish;
	end

endmodule : mipsTb

/* filelist.f */
design/mipsPkg.sv
design/pipeRegister.sv
design/fetchStage.sv
design/controller.sv
design/decodeStage.sv
design/executeStage.sv
design/hazardUnit.sv
design/mips.sv
test/mipsTb.sv
